// ==== source/mac_pkg.sv ====
`default_nettype none

package mac_pkg;

    // ------------------------------------------------------------------
    // datapath widths
    // ------------------------------------------------------------------

    // multiplier operands
    localparam int OP_WIDTH  = 16;
    // accumulator addend
    localparam int ACC_WIDTH = 32;
    // a*b + acc + cin stays below 2^33, one bit above the accumulator
    localparam int RES_WIDTH = ACC_WIDTH + 1;
    // one shifted row per multiplier bit
    localparam int PP_ROWS   = OP_WIDTH;

    typedef logic [OP_WIDTH-1:0]  operand_t;
    typedef logic [ACC_WIDTH-1:0] acc_t;
    // partial products, reduction rows and the result
    typedef logic [RES_WIDTH-1:0] row_t;

    // four-phase req/ack controller
    typedef enum logic [1:0] {
        HS_IDLE,
        HS_BUSY,
        HS_DONE
    } hs_state_e;

endpackage

`default_nettype wire

// ==== source/partial_product_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module partial_product_gen (
    input  wire mac_pkg::operand_t a,
    input  wire mac_pkg::operand_t b,
    output mac_pkg::row_t          pp_rows [mac_pkg::PP_ROWS]
);

    // ------------------------------------------------------------------
    // AND array
    // ------------------------------------------------------------------

    for (genvar i = 0; i < mac_pkg::PP_ROWS; i++) begin : g_row
        // a gated by a single bit of b
        mac_pkg::operand_t and_row;
        // same row widened to the result width
        mac_pkg::row_t     wide_row;

        for (genvar j = 0; j < mac_pkg::OP_WIDTH; j++) begin : g_bit
            assign and_row[j] = a[j] & b[i];
        end

        // zero extension keeps the upper bits clear before the shift
        assign wide_row = mac_pkg::row_t'(and_row);

        // row i carries weight 2^i
        assign pp_rows[i] = wide_row << i;
    end

    // bits below i and above i+15 of row i are constant zero,
    // the reducer relies on the full RES_WIDTH rows regardless

endmodule

`default_nettype wire

// ==== source/wallace_reducer.sv ====
`timescale 1ns/1ps
`default_nettype none

module wallace_reducer (
    input  wire mac_pkg::row_t pp_rows [mac_pkg::PP_ROWS],
    input  wire mac_pkg::acc_t acc,
    output mac_pkg::row_t      sum_row,
    output mac_pkg::row_t      carry_row
);

    // partial products plus the accumulator row
    localparam int IN_ROWS = mac_pkg::PP_ROWS + 1;

    // rows left after one layer of 3:2 compressors
    function automatic int rows_after(input int n);
        return 2 * (n / 3) + n % 3;
    endfunction

    // rows entering a given layer
    function automatic int rows_at(input int layer);
        int n;
        n = IN_ROWS;
        for (int k = 0; k < layer; k++) begin
            n = rows_after(n);
        end
        return n;
    endfunction

    // layers needed to get down to two rows
    function automatic int count_layers(input int n);
        int layers;
        layers = 0;
        while (n > 2) begin
            n = rows_after(n);
            layers++;
        end
        return layers;
    endfunction

    // 17 -> 12 -> 8 -> 6 -> 4 -> 3 -> 2
    localparam int LAYERS = count_layers(IN_ROWS);

    // stage[l] holds the rows entering layer l, spare slots tied low
    mac_pkg::row_t stage [LAYERS+1][IN_ROWS];

    // ------------------------------------------------------------------
    // layer 0 inputs
    // ------------------------------------------------------------------

    for (genvar r = 0; r < mac_pkg::PP_ROWS; r++) begin : g_pp
        assign stage[0][r] = pp_rows[r];
    end

    // accumulator joins as the seventeenth row
    assign stage[0][mac_pkg::PP_ROWS] = mac_pkg::row_t'(acc);

    // ------------------------------------------------------------------
    // compressor layers
    // ------------------------------------------------------------------

    for (genvar l = 0; l < LAYERS; l++) begin : g_layer
        localparam int N_IN   = rows_at(l);
        localparam int GROUPS = N_IN / 3;
        localparam int N_OUT  = rows_after(N_IN);

        for (genvar g = 0; g < GROUPS; g++) begin : g_csa
            mac_pkg::row_t x;
            mac_pkg::row_t y;
            mac_pkg::row_t z;
            // bitwise majority, i.e. the full-adder carries
            mac_pkg::row_t maj;

            assign x   = stage[l][3*g];
            assign y   = stage[l][3*g+1];
            assign z   = stage[l][3*g+2];
            assign maj = (x & y) | (x & z) | (y & z);

            assign stage[l+1][2*g] = x ^ y ^ z;
            // carry out of the top bit is dropped, the total fits in RES_WIDTH
            assign stage[l+1][2*g+1] = {maj[mac_pkg::RES_WIDTH-2:0], 1'b0};
        end

        // leftover rows pass straight through
        for (genvar k = 2 * GROUPS; k < IN_ROWS; k++) begin : g_rest
            if (k < N_OUT) begin : g_pass
                assign stage[l+1][k] = stage[l][k+GROUPS];
            end else begin : g_unused
                assign stage[l+1][k] = '0;
            end
        end
    end

    assign sum_row   = stage[LAYERS][0];
    assign carry_row = stage[LAYERS][1];

endmodule

`default_nettype wire

// ==== source/brent_kung_adder.sv ====
`timescale 1ns/1ps
`default_nettype none

module brent_kung_adder #(
    parameter int WIDTH = mac_pkg::RES_WIDTH
) (
    input  wire [WIDTH-1:0] x,
    input  wire [WIDTH-1:0] y,
    input  wire             cin,
    output logic [WIDTH-1:0] sum
);

    // prefix tree depth
    localparam int LEVELS = $clog2(WIDTH);

    // bitwise propagate, kept for the final xor
    logic [WIDTH-1:0] prop;

    // up-sweep, level s combines spans of 2^s bits
    logic [WIDTH-1:0] up_g [LEVELS+1];
    logic [WIDTH-1:0] up_p [LEVELS+1];

    // down-sweep, only generate is needed since the left side is a full prefix
    logic [WIDTH-1:0] dn_g [LEVELS+1];

    // carries into each bit
    logic [WIDTH-1:0] carry_in;

    // ------------------------------------------------------------------
    // generate and propagate
    // ------------------------------------------------------------------

    assign prop = x ^ y;

    // cin folded into bit 0 so the tree needs no extra column
    assign up_g[0] = (x & y) | {{(WIDTH-1){1'b0}}, prop[0] & cin};
    assign up_p[0] = prop;

    // ------------------------------------------------------------------
    // up-sweep
    // ------------------------------------------------------------------

    for (genvar s = 0; s < LEVELS; s++) begin : g_up
        for (genvar i = 0; i < WIDTH; i++) begin : g_bit
            if ((i + 1) % (2 ** (s + 1)) == 0) begin : g_node
                assign up_g[s+1][i] = up_g[s][i] | (up_p[s][i] & up_g[s][i-2**s]);
                assign up_p[s+1][i] = up_p[s][i] & up_p[s][i-2**s];
            end else begin : g_wire
                assign up_g[s+1][i] = up_g[s][i];
                assign up_p[s+1][i] = up_p[s][i];
            end
        end
    end

    // ------------------------------------------------------------------
    // down-sweep
    // ------------------------------------------------------------------

    assign dn_g[0] = up_g[LEVELS];

    // step d works on span 2^s, from the widest span downwards
    for (genvar d = 0; d < LEVELS; d++) begin : g_down
        localparam int S = LEVELS - 1 - d;

        for (genvar i = 0; i < WIDTH; i++) begin : g_bit
            if (((i + 1) % (2 ** (S + 1)) == 2 ** S) && (i + 1 > 2 ** S)) begin : g_node
                assign dn_g[d+1][i] = dn_g[d][i] | (up_p[LEVELS][i] & dn_g[d][i-2**S]);
            end else begin : g_wire
                assign dn_g[d+1][i] = dn_g[d][i];
            end
        end
    end

    // ------------------------------------------------------------------
    // sum
    // ------------------------------------------------------------------

    if (WIDTH > 1) begin : g_carry
        assign carry_in = {dn_g[LEVELS][WIDTH-2:0], cin};
    end else begin : g_carry_single
        assign carry_in = cin;
    end

    // carry out of the top bit is not kept, the sum wraps at 2^WIDTH
    assign sum = prop ^ carry_in;

endmodule

`default_nettype wire

// ==== source/mac_datapath.sv ====
`timescale 1ns/1ps
`default_nettype none

module mac_datapath (
    input  wire                    clk,
    input  wire                    arst_n,
    input  wire                    launch,
    input  wire mac_pkg::operand_t a,
    input  wire mac_pkg::operand_t b,
    input  wire mac_pkg::acc_t     acc,
    input  wire                    cin,
    output logic                   done,
    output mac_pkg::row_t          result
);

    mac_pkg::row_t pp_rows [mac_pkg::PP_ROWS];
    mac_pkg::row_t sum_row;
    mac_pkg::row_t carry_row;

    // pipeline register between reduction and final adder
    mac_pkg::row_t sum_q;
    mac_pkg::row_t carry_q;
    logic          cin_q;
    logic          stage_valid;

    // ------------------------------------------------------------------
    // multiply and reduce
    // ------------------------------------------------------------------

    partial_product_gen u_pp_gen (
        .a       (a),
        .b       (b),
        .pp_rows (pp_rows)
    );

    wallace_reducer u_reducer (
        .pp_rows   (pp_rows),
        .acc       (acc),
        .sum_row   (sum_row),
        .carry_row (carry_row)
    );

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            stage_valid <= 1'b0;
        end else begin
            stage_valid <= launch;
        end
    end

    always_ff @(posedge clk) begin
        if (launch) begin
            sum_q   <= sum_row;
            carry_q <= carry_row;
            cin_q   <= cin;
        end
    end

    // ------------------------------------------------------------------
    // final carry-propagate addition
    // ------------------------------------------------------------------

    brent_kung_adder #(
        .WIDTH (mac_pkg::RES_WIDTH)
    ) u_adder (
        .x   (sum_q),
        .y   (carry_q),
        .cin (cin_q),
        .sum (result)
    );

    // one cycle after launch
    assign done = stage_valid;

    // controller keeps a single item in flight
    a_no_overlap: assert property (@(posedge clk) disable iff (!arst_n)
        stage_valid |-> !launch);

endmodule

`default_nettype wire

// ==== source/mac_handshake.sv ====
`timescale 1ns/1ps
`default_nettype none

module mac_handshake (
    input  wire                    clk,
    input  wire                    arst_n,
    input  wire                    req,
    output logic                   ack,
    input  wire mac_pkg::operand_t a_in,
    input  wire mac_pkg::operand_t b_in,
    input  wire mac_pkg::acc_t     acc_in,
    input  wire                    cin_in,
    output mac_pkg::operand_t      a,
    output mac_pkg::operand_t      b,
    output mac_pkg::acc_t          acc,
    output logic                   cin,
    output logic                   launch,
    input  wire                    done,
    input  wire mac_pkg::row_t     dp_result,
    output mac_pkg::row_t          result
);

    mac_pkg::hs_state_e state;

    // new request seen while idle
    logic capture;
    // datapath result arriving
    logic finish;

    assign capture = (state == mac_pkg::HS_IDLE) && req;
    assign finish  = (state == mac_pkg::HS_BUSY) && done;

    // ------------------------------------------------------------------
    // control FSM
    // ------------------------------------------------------------------

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state  <= mac_pkg::HS_IDLE;
            ack    <= 1'b0;
            launch <= 1'b0;
        end else begin
            // launch follows capture by one cycle
            launch <= capture;
            case (state)
                mac_pkg::HS_IDLE: begin
                    if (capture) begin
                        state <= mac_pkg::HS_BUSY;
                    end
                end
                mac_pkg::HS_BUSY: begin
                    if (finish) begin
                        state <= mac_pkg::HS_DONE;
                        ack   <= 1'b1;
                    end
                end
                mac_pkg::HS_DONE: begin
                    // hold ack until the requester lets go
                    if (!req) begin
                        state <= mac_pkg::HS_IDLE;
                        ack   <= 1'b0;
                    end
                end
                default: begin
                    state <= mac_pkg::HS_IDLE;
                    ack   <= 1'b0;
                end
            endcase
        end
    end

    // operand and result registers
    always_ff @(posedge clk) begin
        if (capture) begin
            a   <= a_in;
            b   <= b_in;
            acc <= acc_in;
            cin <= cin_in;
        end
        if (finish) begin
            result <= dp_result;
        end
    end

    a_ack_needs_req: assert property (@(posedge clk) disable iff (!arst_n)
        $rose(ack) |-> $past(req));

    a_result_held: assert property (@(posedge clk) disable iff (!arst_n)
        ($past(ack) && ack) |-> $stable(result));

endmodule

`default_nettype wire

// ==== source/wallace_mac.sv ====
`timescale 1ns/1ps
`default_nettype none

module wallace_mac (
    input  wire                    clk,
    input  wire                    arst_n,
    input  wire                    req,
    output logic                   ack,
    input  wire mac_pkg::operand_t a,
    input  wire mac_pkg::operand_t b,
    input  wire mac_pkg::acc_t     acc,
    input  wire                    cin,
    output mac_pkg::row_t          result
);

    // captured operands towards the datapath
    mac_pkg::operand_t dp_a;
    mac_pkg::operand_t dp_b;
    mac_pkg::acc_t     dp_acc;
    logic              dp_cin;

    logic              launch;
    logic              done;
    mac_pkg::row_t     dp_result;

    // ------------------------------------------------------------------
    // req/ack front end
    // ------------------------------------------------------------------

    mac_handshake u_handshake (
        .clk       (clk),
        .arst_n    (arst_n),
        .req       (req),
        .ack       (ack),
        .a_in      (a),
        .b_in      (b),
        .acc_in    (acc),
        .cin_in    (cin),
        .a         (dp_a),
        .b         (dp_b),
        .acc       (dp_acc),
        .cin       (dp_cin),
        .launch    (launch),
        .done      (done),
        .dp_result (dp_result),
        .result    (result)
    );

    // ------------------------------------------------------------------
    // multiply-accumulate datapath
    // ------------------------------------------------------------------

    mac_datapath u_datapath (
        .clk    (clk),
        .arst_n (arst_n),
        .launch (launch),
        .a      (dp_a),
        .b      (dp_b),
        .acc    (dp_acc),
        .cin    (dp_cin),
        .done   (done),
        .result (dp_result)
    );

endmodule

`default_nettype wire

// ==== verification/tb_wallace_mac.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_wallace_mac;

    localparam int CLK_PERIOD_NS = 100;
    localparam int RESET_CYCLES  = 4;
    localparam int RANDOM_TXNS   = 200;
    // zeros, all ones, maximum sum, four one-hot pairs
    localparam int CORNER_TXNS   = 7;
    // drive edge + latency + max hold + release + idle check
    localparam int TXN_CYCLES    = 16;
    localparam int MAX_WAIT      = 16;
    localparam longint TIMEOUT_NS = longint'(RESET_CYCLES + 2 + 100
        + (CORNER_TXNS + RANDOM_TXNS) * TXN_CYCLES) * CLK_PERIOD_NS;

    logic              clk;
    logic              arst_n;
    logic              req;
    logic              ack;
    mac_pkg::operand_t a;
    mac_pkg::operand_t b;
    mac_pkg::acc_t     acc;
    logic              cin;
    mac_pkg::row_t     result;

    logic [31:0]       lfsr;
    logic [32:0]       exp_q [$];
    string             name_q [$];

    wallace_mac dut (
        .clk    (clk),
        .arst_n (arst_n),
        .req    (req),
        .ack    (ack),
        .a      (a),
        .b      (b),
        .acc    (acc),
        .cin    (cin),
        .result (result)
    );

    always #(CLK_PERIOD_NS / 2) clk = ~clk;

    // ------------------------------------------------------------------
    // helpers
    // ------------------------------------------------------------------

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // one lfsr step per bit
    task automatic draw_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int k = 0; k < n; k++) begin
            lfsr = lfsr_next(lfsr);
            v = {v[30:0], lfsr[0]};
        end
    endtask

    // exact a*b + acc + cin
    function automatic logic [32:0] ref_mac(input logic [15:0] fa, input logic [15:0] fb,
                                            input logic [31:0] facc, input logic fcin);
        logic [32:0] prod;
        prod = 33'(fa) * 33'(fb);
        return prod + 33'(facc) + 33'(fcin);
    endfunction

    task automatic report_mismatch(input string test, input logic [32:0] expected,
                                   input logic [32:0] actual);
        $display("Fail %s: expected %h, actual %h", test, expected, actual);
        $display("TB FAILED");
        $fatal(1, "mismatch in %s", test);
    endtask

    task automatic report_error(input string what);
        $display("Error: %s", what);
        $display("TB FAILED");
        $fatal(1, "%s", what);
    endtask

    // one full four-phase transaction with latency and release checks
    task automatic run_txn(input string name, input logic [15:0] ta, input logic [15:0] tb,
                           input logic [31:0] tacc, input logic tcin, input int hold);
        int edges;
        @(posedge clk);
        #1;
        a   = ta;
        b   = tb;
        acc = tacc;
        cin = tcin;
        req = 1'b1;
        exp_q.push_back(ref_mac(ta, tb, tacc, tcin));
        name_q.push_back(name);
        edges = 0;
        do begin
            @(posedge clk);
            edges++;
            @(negedge clk);
        end while (!ack && edges < MAX_WAIT);
        assert (ack) else report_error({"ack never rose in ", name});
        assert (edges == 3) else report_mismatch({"latency ", name}, 33'd3, 33'(edges));
        // req held for the extra cycles while the checker watches result
        repeat (hold + 1) begin
            @(posedge clk);
            #1;
            assert (ack) else report_error({"ack dropped while req was held in ", name});
        end
        req = 1'b0;
        @(posedge clk);
        @(negedge clk);
        assert (!ack) else report_error({"ack still high after req fell in ", name});
        @(posedge clk);
        @(negedge clk);
        assert (!ack) else report_error({"ack rose again without req in ", name});
    endtask

    // ------------------------------------------------------------------
    // stimulus
    // ------------------------------------------------------------------

    initial begin : stimulus
        logic [31:0] ra;
        logic [31:0] rb;
        logic [31:0] racc;
        logic [31:0] rcin;
        logic [31:0] rhold;
        clk    = 1'b0;
        arst_n = 1'b0;
        req    = 1'b0;
        a      = '0;
        b      = '0;
        acc    = '0;
        cin    = 1'b0;
        lfsr   = 32'h90929944;

        repeat (RESET_CYCLES) begin
            @(posedge clk);
            #1;
            assert (!ack) else report_error("ack high during reset");
        end
        arst_n = 1'b1;
        @(posedge clk);
        @(negedge clk);
        assert (!ack) else report_error("ack high on the first edge after reset");

        // corner operands
        run_txn("zeros", 16'h0000, 16'h0000, 32'h0000_0000, 1'b0, 0);
        run_txn("ones", 16'hffff, 16'hffff, 32'h0000_0000, 1'b0, 0);
        run_txn("max_sum", 16'hffff, 16'hffff, 32'hffff_ffff, 1'b1, 0);
        for (int i = 0; i < 16; i += 5) begin
            run_txn($sformatf("one_hot_%0d", i), 16'(1 << i), 16'(1 << (15 - i)),
                    32'h0000_0000, 1'b0, 0);
        end

        // random accumulation with random hold times
        for (int t = 0; t < RANDOM_TXNS; t++) begin
            draw_bits(16, ra);
            draw_bits(16, rb);
            draw_bits(32, racc);
            draw_bits(1, rcin);
            draw_bits(3, rhold);
            run_txn($sformatf("random_%0d", t), ra[15:0], rb[15:0], racc, rcin[0],
                    int'(rhold[2:0]));
        end

        assert (exp_q.size() == 0) else report_error("a transaction was never acknowledged");
        $display("TB PASSED");
        $finish;
    end

    // ------------------------------------------------------------------
    // checker
    // ------------------------------------------------------------------

    // compares on every ack cycle, so a held result must not move
    initial begin : compare
        logic        ack_prev;
        logic [32:0] exp_val;
        string       test_name;
        ack_prev  = 1'b0;
        exp_val   = '0;
        test_name = "";
        forever begin
            @(negedge clk);
            if (arst_n && ack) begin
                if (!ack_prev) begin
                    assert (exp_q.size() > 0)
                        else report_error("ack rose with no request outstanding");
                    exp_val   = exp_q.pop_front();
                    test_name = name_q.pop_front();
                end
                assert (result === exp_val) else report_mismatch(test_name, exp_val, result);
            end
            ack_prev = arst_n && ack;
        end
    end

    initial begin : watchdog
        #(TIMEOUT_NS);
        $display("Error: simulation timed out before all transactions finished");
        $display("TB FAILED");
        $fatal(1, "timeout");
    end

endmodule

`default_nettype wire

// ==== flist.f ====
source/mac_pkg.sv
source/partial_product_gen.sv
source/wallace_reducer.sv
source/brent_kung_adder.sv
source/mac_datapath.sv
source/mac_handshake.sv
source/wallace_mac.sv
verification/tb_wallace_mac.sv

// ==== Bender.yml ====
package:
  name: wallace_mac

sources:
  # package first, everything else refers to it
  - source/mac_pkg.sv
  - source/partial_product_gen.sv
  - source/wallace_reducer.sv
  - source/brent_kung_adder.sv
  - source/mac_datapath.sv
  - source/mac_handshake.sv
  - source/wallace_mac.sv

  # simulation only
  - target: test
    files:
      - verification/tb_wallace_mac.sv
